// ==== hw/byte_link_if.sv ====
`timescale 1ns/1ps

interface byte_link_if;

  // rom_fetch to the other blocks
  logic                            load;
  logic [prog_cfg_pkg::BYTE_W-1:0] byte_data;
  logic                            first_ready;

  // ps_serializer requests
  logic                            fetch;
  logic                            advance;

  // ROM is asynchronous, so load answers fetch in the same cycle
  modport fetch_side (
    output load,
    output byte_data,
    output first_ready,
    input  fetch,
    input  advance
  );

  modport stream_side (
    output fetch,
    output advance,
    input  load,
    input  byte_data
  );

  // handshake only waits for the first byte
  modport start_side (
    input first_ready
  );

endinterface

// ==== hw/cfg_handshake.sv ====
`timescale 1ns/1ps

module cfg_handshake (
  input  logic             slow_clk,
  input  logic             sys_rst_l,
  byte_link_if.start_side  link,
  input  logic             nstatus,
  output logic             nconfig,
  output logic             stream_en
);

  prog_state_pkg::hs_state_t           state_q;
  prog_state_pkg::hs_state_t           state_d;
  logic                                nconfig_d;
  logic                                hold_clr;
  logic                                hold_done;
  logic [prog_cfg_pkg::HOLD_CNT_W-1:0] hold_cnt;

  assign hold_done = (hold_cnt == prog_cfg_pkg::HOLD_LAST);

  always_comb begin
    state_d   = state_q;
    nconfig_d = 1'b1;
    hold_clr  = 1'b0;
    case (state_q)
      prog_state_pkg::hs_idle: begin
        // start the reset pulse once byte 0 sits in the shifter
        if (link.first_ready) begin
          nconfig_d = 1'b0;
          state_d   = prog_state_pkg::hs_assert;
        end
      end
      prog_state_pkg::hs_assert: begin
        nconfig_d = 1'b0;
        state_d   = prog_state_pkg::hs_wait_low;
      end
      prog_state_pkg::hs_wait_low: begin
        nconfig_d = 1'b0;
        if (!nstatus) begin
          hold_clr = 1'b1;
          state_d  = prog_state_pkg::hs_hold;
        end
      end
      prog_state_pkg::hs_hold: begin
        if (hold_done) begin
          state_d = prog_state_pkg::hs_wait_high;
        end else begin
          nconfig_d = 1'b0;
        end
      end
      prog_state_pkg::hs_wait_high: begin
        // FPGA releases nstatus when it is ready for data
        if (nstatus) begin
          state_d = prog_state_pkg::hs_stream;
        end
      end
      prog_state_pkg::hs_stream: begin
        state_d = prog_state_pkg::hs_stream;
      end
      default: begin
        state_d = prog_state_pkg::hs_idle;
      end
    endcase
  end

  always_ff @(posedge slow_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      state_q  <= prog_state_pkg::hs_idle;
      nconfig  <= 1'b1;
      hold_cnt <= '0;
    end else begin
      state_q <= state_d;
      // registered so nconfig never glitches
      nconfig <= nconfig_d;
      if (hold_clr) begin
        hold_cnt <= '0;
      end else if (state_q == prog_state_pkg::hs_hold && !hold_done) begin
        hold_cnt <= hold_cnt + 1'b1;
      end
    end
  end

  assign stream_en = (state_q == prog_state_pkg::hs_stream);

endmodule

// ==== hw/prog_cfg_pkg.sv ====
package prog_cfg_pkg;

  // parallel config ROM, 32 KB maximum
  localparam int ROM_ADDR_W = 15;
  localparam int BYTE_W = 8;

  // bit counter inside one serialized byte
  localparam int BIT_CNT_W = $clog2(BYTE_W);
  localparam logic [BIT_CNT_W-1:0] BITS_PER_BYTE_LAST = 3'd7;

  // minimum nconfig low time, counted in slow_clk cycles
  // once the FPGA has pulled nstatus low
  localparam int NCFG_HOLD_CYCLES = 8;
  localparam int HOLD_CNT_W = $clog2(NCFG_HOLD_CYCLES);

  // last value of the hold counter before nconfig is released
  localparam logic [HOLD_CNT_W-1:0] HOLD_LAST = HOLD_CNT_W'(NCFG_HOLD_CYCLES - 1);

endpackage

// ==== hw/prog_state_pkg.sv ====
package prog_state_pkg;

  // FPGA reset handshake
  typedef enum logic [2:0] {
    hs_idle      = 3'd0,
    // nconfig driven low, nstatus not yet checked
    hs_assert    = 3'd1,
    hs_wait_low  = 3'd2,
    // nconfig held low for the minimum time
    hs_hold      = 3'd3,
    hs_wait_high = 3'd4,
    hs_stream    = 3'd5
  } hs_state_t;

  // passive-serial byte stream
  typedef enum logic [2:0] {
    ser_wait      = 3'd0,
    // one dclk pulse per cycle
    ser_shift     = 3'd1,
    // gap cycle between bytes, conf_done checked here
    ser_next      = 3'd2,
    ser_conf_done = 3'd3,
    ser_done      = 3'd4
  } ser_state_t;

endpackage

// ==== hw/prog_top.sv ====
`timescale 1ns/1ps

module prog_top (
  input  logic                                slow_clk,
  input  logic                                sys_rst_l,

  // config ROM
  output logic                                rom_cs_l,
  output logic                                rom_rd_l,
  output logic [prog_cfg_pkg::ROM_ADDR_W-1:0] rom_addr,
  input  logic [prog_cfg_pkg::BYTE_W-1:0]     rom_data,

  // FPGA passive-serial port
  output logic                                nconfig,
  output logic                                data0,
  output logic                                dclk,
  input  logic                                nstatus,
  input  logic                                conf_done,
  input  logic                                init_done,

  output logic                                prog_active
);

  logic stream_en;

  byte_link_if link_i ();

  rom_fetch rom_fetch_i (
    .slow_clk  (slow_clk),
    .sys_rst_l (sys_rst_l),
    .link      (link_i.fetch_side),
    .rom_cs_l  (rom_cs_l),
    .rom_rd_l  (rom_rd_l),
    .rom_addr  (rom_addr),
    .rom_data  (rom_data)
  );

  // nconfig / nstatus reset sequence
  cfg_handshake cfg_handshake_i (
    .slow_clk  (slow_clk),
    .sys_rst_l (sys_rst_l),
    .link      (link_i.start_side),
    .nstatus   (nstatus),
    .nconfig   (nconfig),
    .stream_en (stream_en)
  );

  ps_serializer ps_serializer_i (
    .slow_clk    (slow_clk),
    .sys_rst_l   (sys_rst_l),
    .link        (link_i.stream_side),
    .stream_en   (stream_en),
    .conf_done   (conf_done),
    .init_done   (init_done),
    .data0       (data0),
    .dclk        (dclk),
    .prog_active (prog_active)
  );

endmodule

// ==== hw/ps_serializer.sv ====
`timescale 1ns/1ps

module ps_serializer (
  input  logic             slow_clk,
  input  logic             sys_rst_l,
  byte_link_if.stream_side link,
  input  logic             stream_en,
  input  logic             conf_done,
  input  logic             init_done,
  output logic             data0,
  output logic             dclk,
  output logic             prog_active
);

  prog_state_pkg::ser_state_t         state_q;
  prog_state_pkg::ser_state_t         state_d;
  logic [prog_cfg_pkg::BYTE_W-1:0]    shift_q;
  logic [prog_cfg_pkg::BIT_CNT_W-1:0] bit_cnt;
  logic                               bit_last;
  logic                               cnt_clr;
  logic                               dclk_en;
  logic                               fetch_req;
  logic                               advance_req;

  assign bit_last = (bit_cnt == prog_cfg_pkg::BITS_PER_BYTE_LAST);

  always_comb begin
    state_d     = state_q;
    dclk_en     = 1'b0;
    cnt_clr     = 1'b0;
    fetch_req   = 1'b0;
    advance_req = 1'b0;
    case (state_q)
      prog_state_pkg::ser_wait: begin
        if (stream_en) begin
          cnt_clr = 1'b1;
          state_d = prog_state_pkg::ser_shift;
        end
      end
      prog_state_pkg::ser_shift: begin
        dclk_en = 1'b1;
        // next byte lands in the shifter on the same edge as bit 7 leaves
        if (bit_last) begin
          fetch_req = 1'b1;
          state_d   = prog_state_pkg::ser_next;
        end
      end
      prog_state_pkg::ser_next: begin
        if (conf_done) begin
          state_d = prog_state_pkg::ser_conf_done;
        end else begin
          advance_req = 1'b1;
          cnt_clr     = 1'b1;
          state_d     = prog_state_pkg::ser_shift;
        end
      end
      prog_state_pkg::ser_conf_done: begin
        // extra clocks for FPGA initialization
        dclk_en = 1'b1;
        if (init_done) begin
          state_d = prog_state_pkg::ser_done;
        end
      end
      prog_state_pkg::ser_done: begin
        state_d = prog_state_pkg::ser_done;
      end
      default: begin
        state_d = prog_state_pkg::ser_wait;
      end
    endcase
  end

  always_ff @(posedge slow_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      state_q <= prog_state_pkg::ser_wait;
      bit_cnt <= '0;
    end else begin
      state_q <= state_d;
      if (cnt_clr) begin
        bit_cnt <= '0;
      end else if (state_q == prog_state_pkg::ser_shift) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // lsb first, shift right
  always_ff @(posedge slow_clk) begin
    if (link.load) begin
      shift_q <= link.byte_data;
    end else if (state_q == prog_state_pkg::ser_shift) begin
      shift_q <= {1'b0, shift_q[prog_cfg_pkg::BYTE_W-1:1]};
    end
  end

  assign link.fetch   = fetch_req;
  assign link.advance = advance_req;

  // dclk rises mid-cycle, data0 already settled since the rising slow_clk
  assign data0       = shift_q[0];
  assign dclk        = ~slow_clk & dclk_en;
  assign prog_active = (state_q != prog_state_pkg::ser_done);

endmodule

// ==== hw/rom_fetch.sv ====
`timescale 1ns/1ps

module rom_fetch (
  input  logic                                slow_clk,
  input  logic                                sys_rst_l,
  byte_link_if.fetch_side                     link,
  output logic                                rom_cs_l,
  output logic                                rom_rd_l,
  output logic [prog_cfg_pkg::ROM_ADDR_W-1:0] rom_addr,
  input  logic [prog_cfg_pkg::BYTE_W-1:0]     rom_data
);

  logic                                armed;
  logic                                prefetched;
  logic                                prefetch_req;
  logic                                read_req;
  logic [prog_cfg_pkg::ROM_ADDR_W-1:0] addr_q;

  // one-shot read of byte 0 in the first cycle after reset
  assign prefetch_req = armed & ~prefetched;
  assign read_req     = prefetch_req | link.fetch;

  always_ff @(posedge slow_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      armed      <= 1'b0;
      prefetched <= 1'b0;
    end else begin
      armed <= 1'b1;
      if (prefetch_req) begin
        prefetched <= 1'b1;
      end
    end
  end

  // address pointer, steps past byte 0 after the prefetch
  always_ff @(posedge slow_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      addr_q <= '0;
    end else if (prefetch_req || link.advance) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  // cs and rd only low for the cycle of a read
  assign rom_cs_l = ~read_req;
  assign rom_rd_l = ~read_req;
  assign rom_addr = addr_q;

  // async ROM data is valid within the read cycle
  assign link.load        = read_req;
  assign link.byte_data   = rom_data;
  assign link.first_ready = prefetched;

endmodule

// ==== list.f ====
hw/prog_cfg_pkg.sv
hw/prog_state_pkg.sv
hw/byte_link_if.sv
hw/rom_fetch.sv
hw/cfg_handshake.sv
hw/ps_serializer.sv
hw/prog_top.sv
tb/prog_sva.sv
tb/tb_prog.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_prog -f list.f -o sim_prog
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_prog)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
  exit 0
else
  exit 1
fi

// ==== tb/prog_sva.sv ====
`timescale 1ns/1ps

module prog_sva (
  input logic                                slow_clk,
  input logic                                sys_rst_l,
  input logic                                rom_cs_l,
  input logic                                rom_rd_l,
  input logic [prog_cfg_pkg::ROM_ADDR_W-1:0] rom_addr,
  input logic                                nconfig,
  input logic                                dclk,
  input logic                                nstatus,
  input logic                                prog_active
);

  int   fail_cnt = 0;
  logic nstatus_fell;
  logic fpga_ready;

  // FPGA ready once nstatus went low and came back high
  always @(posedge slow_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      nstatus_fell <= 1'b0;
      fpga_ready   <= 1'b0;
    end else if (!nstatus) begin
      nstatus_fell <= 1'b1;
    end else if (nstatus_fell) begin
      fpga_ready <= 1'b1;
    end
  end

  // idle levels in the first cycle out of reset
  reset_levels: assert property (
    @(posedge slow_clk) $rose(sys_rst_l) |->
      nconfig && rom_cs_l && rom_rd_l && !dclk && prog_active
  ) else begin
    fail_cnt++;
    $error("outputs not idle when reset was released");
  end

  rd_inside_cs: assert property (
    @(posedge slow_clk) disable iff (!sys_rst_l) !rom_rd_l |-> !rom_cs_l
  ) else begin
    fail_cnt++;
    $error("ROM read strobe low while chip select is high");
  end

  // pointer only ever steps by one
  addr_step: assert property (
    @(posedge slow_clk) disable iff (!sys_rst_l)
      rom_addr != $past(rom_addr) |-> rom_addr == $past(rom_addr) + 1'b1
  ) else begin
    fail_cnt++;
    $error("ROM address did not step by one");
  end

  // nstatus seen low exactly NCFG_HOLD_CYCLES samples before nconfig rises
  hold_time: assert property (
    @(posedge slow_clk) disable iff (!sys_rst_l)
      $rose(nconfig) |->
        !$past(nstatus, prog_cfg_pkg::NCFG_HOLD_CYCLES + 1) &&
        $past(nstatus, prog_cfg_pkg::NCFG_HOLD_CYCLES + 2)
  ) else begin
    fail_cnt++;
    $error("nconfig low time after nstatus fell is wrong");
  end

  // every dclk pulse needs a finished handshake and an active loader
  dclk_gate: assert property (
    @(posedge dclk) disable iff (!sys_rst_l)
      fpga_ready && nconfig && nstatus && prog_active
  ) else begin
    fail_cnt++;
    $error("dclk pulse outside the streaming phase");
  end

  done_sticky: assert property (
    @(posedge slow_clk) disable iff (!sys_rst_l) !prog_active |=> !prog_active
  ) else begin
    fail_cnt++;
    $error("prog_active rose again after the end of configuration");
  end

endmodule

bind prog_top prog_sva prog_sva_i (
  .slow_clk    (slow_clk),
  .sys_rst_l   (sys_rst_l),
  .rom_cs_l    (rom_cs_l),
  .rom_rd_l    (rom_rd_l),
  .rom_addr    (rom_addr),
  .nconfig     (nconfig),
  .dclk        (dclk),
  .nstatus     (nstatus),
  .prog_active (prog_active)
);

// ==== tb/tb_prog.sv ====
`timescale 1ns/1ps

module tb_prog;

  // FPGA model raises conf_done after this many bytes
  int conf_bytes = 20;
  // and init_done after this many extra dclk pulses
  int init_pulses = 5;
  int timeout_cycles;

  logic                                slow_clk;
  logic                                sys_rst_l;
  logic                                rom_cs_l;
  logic                                rom_rd_l;
  logic [prog_cfg_pkg::ROM_ADDR_W-1:0] rom_addr;
  logic [prog_cfg_pkg::BYTE_W-1:0]     rom_data;
  logic                                nconfig;
  logic                                data0;
  logic                                dclk;
  logic                                nstatus;
  logic                                conf_done;
  logic                                init_done;
  logic                                prog_active;

  logic [prog_cfg_pkg::BYTE_W-1:0] rom [0:63];
  logic [prog_cfg_pkg::BYTE_W-1:0] got_byte;
  integer seed;
  integer rnd;
  int bit_errs;
  int byte_errs;
  int check_errs;
  int sva_errs;
  int stream_bits;
  int tail_bits;
  int late_bits;
  int fpga_phase;
  int wait_cnt;
  int cycles;

  always #50 slow_clk = ~slow_clk;

  // asynchronous ROM, floats high when not read
  assign rom_data = (!rom_cs_l && !rom_rd_l) ? rom[rom_addr[5:0]] : '1;

  prog_top dut_i (
    .slow_clk    (slow_clk),
    .sys_rst_l   (sys_rst_l),
    .rom_cs_l    (rom_cs_l),
    .rom_rd_l    (rom_rd_l),
    .rom_addr    (rom_addr),
    .rom_data    (rom_data),
    .nconfig     (nconfig),
    .data0       (data0),
    .dclk        (dclk),
    .nstatus     (nstatus),
    .conf_done   (conf_done),
    .init_done   (init_done),
    .prog_active (prog_active)
  );

  // FPGA side of the reset handshake
  always @(negedge slow_clk) begin
    if (!sys_rst_l) begin
      nstatus    <= 1'b1;
      conf_done  <= 1'b0;
      init_done  <= 1'b0;
      fpga_phase <= 0;
      wait_cnt   <= 0;
    end else begin
      case (fpga_phase)
        0: begin
          // pull nstatus low on the third edge with nconfig low
          if (!nconfig) begin
            if (wait_cnt == 2) begin
              nstatus    <= 1'b0;
              fpga_phase <= 1;
              wait_cnt   <= 0;
            end else begin
              wait_cnt <= wait_cnt + 1;
            end
          end
        end
        1: begin
          if (nconfig) begin
            if (wait_cnt == 1) begin
              nstatus    <= 1'b1;
              fpga_phase <= 2;
            end else begin
              wait_cnt <= wait_cnt + 1;
            end
          end
        end
        default: begin
          if (stream_bits >= conf_bytes * 8) begin
            conf_done <= 1'b1;
          end
          if (conf_done && tail_bits >= init_pulses) begin
            init_done <= 1'b1;
          end
        end
      endcase
    end
  end

  // data0 is sampled the way the FPGA does, on rising dclk
  always @(posedge dclk) begin : dclk_monitor
    logic [prog_cfg_pkg::BYTE_W-1:0] assembled;
    logic [5:0]                      byte_idx;
    logic [2:0]                      bit_idx;
    if (init_done) begin
      late_bits <= late_bits + 1;
    end else if (conf_done) begin
      tail_bits <= tail_bits + 1;
    end else begin
      byte_idx  = 6'(stream_bits / 8);
      bit_idx   = 3'(stream_bits % 8);
      assembled = {data0, got_byte[7:1]};
      assert (data0 == rom[byte_idx][bit_idx]) else begin
        bit_errs++;
        $display("[FAIL] data0 byte %0d bit %0d expected %h got %h",
                 byte_idx, bit_idx, rom[byte_idx][bit_idx], data0);
      end
      if (bit_idx == 3'd7) begin
        assert (assembled == rom[byte_idx]) else begin
          byte_errs++;
          $display("[FAIL] data0 byte %0d expected %h got %h",
                   byte_idx, rom[byte_idx], assembled);
        end
      end
      got_byte    <= assembled;
      stream_bits <= stream_bits + 1;
    end
  end

  idle_after_init: assert property (
    @(posedge slow_clk) disable iff (!sys_rst_l) init_done |=> !prog_active
  ) else begin
    check_errs++;
    $display("prog_active still high one cycle after init_done");
  end

  initial begin
    slow_clk    = 1'b0;
    sys_rst_l   = 1'b0;
    nstatus     = 1'b1;
    conf_done   = 1'b0;
    init_done   = 1'b0;
    got_byte    = '0;
    bit_errs    = 0;
    byte_errs   = 0;
    check_errs  = 0;
    sva_errs    = 0;
    stream_bits = 0;
    tail_bits   = 0;
    late_bits   = 0;
    seed        = 26;
    for (int i = 0; i < 64; i++) begin
      rnd    = $random(seed);
      rom[i] = rnd[7:0];
    end

    repeat (10) @(negedge slow_clk);
    sys_rst_l = 1'b1;

    // loader drops prog_active once init_done was seen
    while (prog_active) begin
      @(negedge slow_clk);
    end
    repeat (4) @(negedge slow_clk);

    assert (stream_bits == conf_bytes * 8) else begin
      check_errs++;
      $display("[FAIL] stream_bits expected %h got %h", conf_bytes * 8, stream_bits);
    end
    assert (tail_bits >= init_pulses) else begin
      check_errs++;
      $display("dclk stopped after conf_done before init_done was raised");
    end
    assert (late_bits == 0) else begin
      check_errs++;
      $display("[FAIL] late_bits expected %h got %h", 0, late_bits);
    end

    sva_errs = dut_i.prog_sva_i.fail_cnt;
    $display("bit errors %0d, byte errors %0d, assertion errors %0d, other errors %0d",
             bit_errs, byte_errs, sva_errs, check_errs);
    if (bit_errs + byte_errs + sva_errs + check_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // reset, handshake, 9 cycles per byte, then a margin
  initial begin
    timeout_cycles = 10 + 30 + conf_bytes * 9 + 100;
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge slow_clk);
      cycles++;
    end
    $display("Timeout: configuration did not finish within %0d cycles", timeout_cycles);
    $display("Test failed");
    $finish;
  end

endmodule
